//--- sources.f
rtl/dmaPkg.sv
rtl/hostPort.sv
rtl/channelRegisters.sv
rtl/controlRegisters.sv
rtl/transferCounter.sv
rtl/dmaDatapath.sv
bench/dmaChecker.sv
bench/tbTop.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
rm -rf obj_dir sim.log
verilator --binary --timing -f sources.f --top-module tbTop -Mdir obj_dir > build.log 2>&1 \
  && ./obj_dir/VtbTop > sim.log 2>&1 \
  && cat sim.log \
  && ! grep -q "test failed" sim.log \
  && echo "simulation run passed" \
  || { cat build.log sim.log 2>/dev/null; echo "simulation run failed"; exit 1; }

//--- bench/tbTop.sv
`timescale 1ns/1ps

module tbTop
  import dmaPkg::*;
();

  // planned cycles per test with two cycles for each host op or strobe
  localparam int resetCycles = 10;
  localparam int idleTestCycles = 6;
  localparam int pointerTestCycles = 64;
  localparam int controlTestCycles = 26;
  localparam int transferTestCycles = 80;
  localparam int statusTestCycles = 28;
  localparam int closingCycles = 8;
  localparam int timeoutCycles = 4 * (resetCycles + idleTestCycles + pointerTestCycles
                                      + controlTestCycles + transferTestCycles
                                      + statusTestCycles + closingCycles);

  logic                               busIf;
  logic                               arstN;
  logic                               csN;
  logic                               iorN;
  logic                               iowN;
  logic [3:0]                         regAddress;
  logic [dataWidth-1:0]               writeData;
  logic [channels-1:0]                dreq;
  logic [channels-1:0]                dack;
  logic                               loadTransfer;
  logic                               stepTransfer;
  logic                               writeBack;
  logic [dataWidth-1:0]               readData;
  logic [dataWidth-1:0]               command;
  logic [channels-1:0][modeWidth-1:0] channelMode;
  logic [addressWidth-1:0]            memAddress;
  int                                 testNumber;
  logic                               testEnd;
  logic                               runDone;
  int                                 errorCount;
  int                                 cycleCount = 0;
  int                                 channel;
  int                                 stepCount;

  always #20 busIf = ~busIf;

  dmaDatapath DUT (
    .busIf        (busIf),
    .arstN        (arstN),
    .csN          (csN),
    .iorN         (iorN),
    .iowN         (iowN),
    .regAddress   (regAddress),
    .writeData    (writeData),
    .dreq         (dreq),
    .dack         (dack),
    .loadTransfer (loadTransfer),
    .stepTransfer (stepTransfer),
    .writeBack    (writeBack),
    .readData     (readData),
    .command      (command),
    .channelMode  (channelMode),
    .memAddress   (memAddress)
  );

  dmaChecker scoreboard (
    .busIf        (busIf),
    .arstN        (arstN),
    .csN          (csN),
    .iorN         (iorN),
    .iowN         (iowN),
    .regAddress   (regAddress),
    .writeData    (writeData),
    .dreq         (dreq),
    .dack         (dack),
    .loadTransfer (loadTransfer),
    .stepTransfer (stepTransfer),
    .writeBack    (writeBack),
    .readData     (readData),
    .command      (command),
    .channelMode  (channelMode),
    .memAddress   (memAddress),
    .testNumber   (testNumber),
    .testEnd      (testEnd),
    .runDone      (runDone),
    .errorCount   (errorCount)
  );

  // one strobe cycle and one idle cycle
  task automatic hostWrite(input logic [3:0] address, input logic [dataWidth-1:0] data);
    @(negedge busIf);
    csN = 1'b0;
    iowN = 1'b0;
    regAddress = address;
    writeData = data;
    @(negedge busIf);
    csN = 1'b1;
    iowN = 1'b1;
  endtask

  task automatic hostRead(input logic [3:0] address);
    @(negedge busIf);
    csN = 1'b0;
    iorN = 1'b0;
    regAddress = address;
    @(negedge busIf);
    csN = 1'b1;
    iorN = 1'b1;
  endtask

  // low byte first through the byte pointer
  task automatic writeWord(input logic [3:0] address, input logic [addressWidth-1:0] word);
    hostWrite(address, word[7:0]);
    hostWrite(address, word[15:8]);
  endtask

  task automatic readWord(input logic [3:0] address);
    hostRead(address);
    hostRead(address);
  endtask

  task automatic driveStrobes(input logic load, input logic step, input logic back);
    @(negedge busIf);
    loadTransfer = load;
    stepTransfer = step;
    writeBack = back;
    @(negedge busIf);
    loadTransfer = 1'b0;
    stepTransfer = 1'b0;
    writeBack = 1'b0;
  endtask

  task automatic programChannel(input int ch, input logic [addressWidth-1:0] address,
                                input logic [addressWidth-1:0] count);
    hostWrite(4'd12, 8'h00);
    writeWord(4'(2 * ch), address);
    writeWord(4'(2 * ch + 1), count);
  endtask

  task automatic runTransfer(input int ch, input int steps, input logic [channels-1:0] requests);
    dack = channels'(1) << ch;
    driveStrobes(1'b1, 1'b0, 1'b0);
    repeat (steps) driveStrobes(1'b0, 1'b1, 1'b0);
    dreq = requests;
    driveStrobes(1'b0, 1'b0, 1'b1);
    dack = '0;
  endtask

  task automatic finishTest(input int number);
    // last read reaches readData one cycle after its task returns
    @(negedge busIf);
    testNumber = number;
    testEnd = 1'b1;
    @(negedge busIf);
    testEnd = 1'b0;
  endtask

  always @(posedge busIf)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles)
    begin
      $display("run timed out after %0d cycles without finishing the tests", cycleCount);
      $display("test failed");
      $finish;
    end
  end

  initial
  begin
    busIf = 1'b0;
    arstN = 1'b0;
    csN = 1'b1;
    iorN = 1'b1;
    iowN = 1'b1;
    regAddress = '0;
    writeData = '0;
    dreq = '0;
    dack = '0;
    loadTransfer = 1'b0;
    stepTransfer = 1'b0;
    writeBack = 1'b0;
    testNumber = 0;
    testEnd = 1'b0;
    runDone = 1'b0;
    void'($urandom(7));
    repeat (resetCycles) @(negedge busIf);
    arstN = 1'b1;

    // reset values and an empty status
    repeat (2) @(negedge busIf);
    hostRead(4'd8);
    finishTest(1);

    for (int ch = 0; ch < channels; ch++)
    begin
      writeWord(4'(2 * ch), 16'($urandom));
      writeWord(4'(2 * ch + 1), 16'($urandom));
    end
    for (int ch = 0; ch < channels; ch++)
    begin
      readWord(4'(2 * ch));
      readWord(4'(2 * ch + 1));
    end
    finishTest(2);

    // a lone byte leaves the pointer high until cleared
    hostWrite(4'd0, 8'($urandom));
    hostWrite(4'd12, 8'h00);
    hostWrite(4'd0, 8'($urandom));
    hostWrite(4'd12, 8'h00);
    readWord(4'd0);
    hostWrite(4'd8, 8'($urandom));
    hostWrite(4'd8, 8'($urandom));
    repeat (4) hostWrite(4'd11, {6'($urandom), 2'($urandom)});
    finishTest(3);

    repeat (2)
    begin
      channel = int'($urandom % channels);
      stepCount = 1 + int'($urandom % 8);
      programChannel(channel, 16'($urandom), 16'($urandom));
      runTransfer(channel, stepCount, channels'($urandom));
      hostWrite(4'd12, 8'h00);
      readWord(4'(2 * channel));
      readWord(4'(2 * channel + 1));
    end
    finishTest(4);

    // count stepped down to zero sets terminal count
    hostRead(4'd8);
    channel = int'($urandom % channels);
    stepCount = 1 + int'($urandom % 4);
    programChannel(channel, 16'($urandom), 16'(stepCount));
    runTransfer(channel, stepCount, channels'($urandom));
    hostRead(4'd8);
    hostRead(4'd8);
    finishTest(5);

    runDone = 1'b1;
    @(negedge busIf);
    runDone = 1'b0;
    if (errorCount == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

//--- bench/dmaChecker.sv
`timescale 1ns/1ps

module dmaChecker
  import dmaPkg::*;
(
  input  logic                               busIf,
  input  logic                               arstN,
  input  logic                               csN,
  input  logic                               iorN,
  input  logic                               iowN,
  input  logic [3:0]                         regAddress,
  input  logic [dataWidth-1:0]               writeData,
  input  logic [channels-1:0]                dreq,
  input  logic [channels-1:0]                dack,
  input  logic                               loadTransfer,
  input  logic                               stepTransfer,
  input  logic                               writeBack,
  input  logic [dataWidth-1:0]               readData,
  input  logic [dataWidth-1:0]               command,
  input  logic [channels-1:0][modeWidth-1:0] channelMode,
  input  logic [addressWidth-1:0]            memAddress,
  input  int                                 testNumber,
  input  logic                               testEnd,
  input  logic                               runDone,
  output int                                 errorCount
);

  // reference model of the programmable registers
  logic [addressWidth-1:0] modelAddress [channels];
  logic [addressWidth-1:0] modelCount [channels];
  logic [modeWidth-1:0]    modelMode [channels];
  logic [dataWidth-1:0]    modelCommand;
  logic [dataWidth-1:0]    modelStatus;
  logic [dataWidth-1:0]    modelRead;
  logic [addressWidth-1:0] modelTempAddress;
  logic [addressWidth-1:0] modelTempCount;
  logic                    modelPointer;
  // host access sampled one edge earlier
  regOpT                   pendingOp;
  logic [1:0]              pendingChannel;
  logic [dataWidth-1:0]    pendingData;
  logic                    pendingHigh;
  int                      errors = 0;
  int                      checkCount = 0;
  int                      testErrorStart = 0;
  int                      testsRun = 0;
  int                      testsFailed = 0;

  assign errorCount = errors;

  function automatic regOpT decodeAccess(input logic [3:0] address, input logic isWrite,
                                         input logic isRead);
    if (address < 4'd8 && isWrite)
      return address[0] ? opWrBaseCount : opWrBaseAddress;
    if (address < 4'd8 && isRead)
      return address[0] ? opRdCurCount : opRdCurAddress;
    if (address == 4'd8 && isWrite)
      return opWrCommand;
    if (address == 4'd8 && isRead)
      return opRdStatus;
    if (address == 4'd11 && isWrite)
      return opWrMode;
    if (address == 4'd12 && isWrite)
      return opClearPointer;
    return opNone;
  endfunction

  // expected read byte, from the model before the acting edge
  function automatic logic [dataWidth-1:0] expectedRead(input regOpT op, input logic [1:0] ch,
                                                        input logic high);
    logic [addressWidth-1:0] word;
    if (op == opRdStatus)
      return modelStatus;
    word = (op == opRdCurCount) ? modelCount[ch] : modelAddress[ch];
    return high ? word[15:8] : word[7:0];
  endfunction

  function automatic logic [addressWidth-1:0] withByte(input logic [addressWidth-1:0] word,
                                                       input logic [dataWidth-1:0] data,
                                                       input logic high);
    return high ? {data, word[7:0]} : {word[15:8], data};
  endfunction

  task automatic updateModel();
    logic [1:0]              ackChannel;
    logic                    anyAck;
    logic [addressWidth-1:0] oldTempAddress;
    logic [addressWidth-1:0] oldTempCount;
    logic                    hostWins;
    regOpT                   accessOp;
    ackChannel = '0;
    for (int i = 0; i < channels; i++)
      if (dack[i])
        ackChannel = 2'(i);
    anyAck = |dack;
    oldTempAddress = modelTempAddress;
    oldTempCount = modelTempCount;
    if (pendingOp inside {opRdCurAddress, opRdCurCount, opRdStatus})
      modelRead = expectedRead(pendingOp, pendingChannel, pendingHigh);
    // a status read clears, even against a writeback
    if (pendingOp == opRdStatus)
      modelStatus = '0;
    else if (writeBack && anyAck)
      modelStatus = {dreq, modelStatus[channels-1:0] | (oldTempCount == '0 ? dack : '0)};
    if (anyAck && loadTransfer)
    begin
      modelTempAddress = modelAddress[ackChannel];
      modelTempCount = modelCount[ackChannel];
    end
    else if (anyAck && stepTransfer)
    begin
      modelTempAddress = modelTempAddress + 16'd1;
      modelTempCount = modelTempCount - 16'd1;
    end
    hostWins = pendingOp inside {opWrBaseAddress, opWrBaseCount} && pendingChannel == ackChannel;
    if (writeBack && anyAck && !hostWins)
    begin
      modelAddress[ackChannel] = oldTempAddress;
      modelCount[ackChannel] = oldTempCount;
    end
    case (pendingOp)
      opWrBaseAddress: modelAddress[pendingChannel] = withByte(modelAddress[pendingChannel],
                                                               pendingData, pendingHigh);
      opWrBaseCount: modelCount[pendingChannel] = withByte(modelCount[pendingChannel],
                                                           pendingData, pendingHigh);
      opWrCommand: modelCommand = pendingData;
      opWrMode: modelMode[pendingData[1:0]] = pendingData[dataWidth-1:dataWidth-modeWidth];
      default: ;
    endcase
    accessOp = decodeAccess(regAddress, !csN && !iowN && iorN, !csN && !iorN && iowN);
    pendingOp = accessOp;
    pendingChannel = (regAddress == 4'd11) ? writeData[1:0] : regAddress[2:1];
    pendingData = writeData;
    pendingHigh = modelPointer;
    if (accessOp == opClearPointer)
      modelPointer = 1'b0;
    else if (accessOp inside {opWrBaseAddress, opWrBaseCount, opRdCurAddress, opRdCurCount})
      modelPointer = ~modelPointer;
  endtask

  always @(posedge busIf or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < channels; i++)
      begin
        modelAddress[i] = '0;
        modelCount[i] = '0;
        modelMode[i] = '0;
      end
      modelCommand = '0;
      modelStatus = '0;
      modelRead = '0;
      modelTempAddress = '0;
      modelTempCount = '0;
      modelPointer = 1'b0;
      pendingOp = opNone;
      pendingChannel = '0;
      pendingData = '0;
      pendingHigh = 1'b0;
    end
    else
      updateModel();
  end

  task automatic checkValue(input string name, input logic [15:0] actual,
                            input logic [15:0] expected);
    checkCount++;
    if (actual !== expected)
    begin
      errors++;
      $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // outputs settle after the rising edge, so compare on the falling one
  always @(negedge busIf)
  begin
    if (arstN)
    begin
      checkValue("readData", 16'(readData), 16'(modelRead));
      checkValue("memAddress", memAddress, modelTempAddress);
      checkValue("command", 16'(command), 16'(modelCommand));
      for (int i = 0; i < channels; i++)
        checkValue($sformatf("channelMode[%0d]", i), 16'(channelMode[i]), 16'(modelMode[i]));
    end
  end

  always @(posedge busIf)
  begin
    if (testEnd)
    begin
      testsRun++;
      if (errors == testErrorStart)
        $display("test %0d ok, %0d checks so far", testNumber, checkCount);
      else
      begin
        testsFailed++;
        $display("test %0d had %0d errors", testNumber, errors - testErrorStart);
      end
      testErrorStart = errors;
    end
    if (runDone)
      $display("tests %0d, failing %0d, checks %0d, errors %0d",
               testsRun, testsFailed, checkCount, errors);
  end

endmodule

//--- rtl/dmaDatapath.sv
`timescale 1ns/1ps

module dmaDatapath
  import dmaPkg::*;
(
  input  logic                               busIf,
  input  logic                               arstN,
  input  logic                               csN,
  input  logic                               iorN,
  input  logic                               iowN,
  input  logic [3:0]                         regAddress,
  input  logic [dataWidth-1:0]               writeData,
  input  logic [channels-1:0]                dreq,
  input  logic [channels-1:0]                dack,
  input  logic                               loadTransfer,
  input  logic                               stepTransfer,
  input  logic                               writeBack,
  output logic [dataWidth-1:0]               readData,
  output logic [dataWidth-1:0]               command,
  output logic [channels-1:0][modeWidth-1:0] channelMode,
  output logic [addressWidth-1:0]            memAddress
);

  regOpT                                 regOp;
  logic [1:0]                            regChannel;
  logic [dataWidth-1:0]                  regData;
  logic                                  highByte;
  logic [channels-1:0][addressWidth-1:0] curAddress;
  logic [channels-1:0][addressWidth-1:0] curCount;
  logic [dataWidth-1:0]                  channelReadByte;
  logic [dataWidth-1:0]                  statusByte;
  logic [addressWidth-1:0]               tempAddress;
  logic [addressWidth-1:0]               tempCount;

  hostPort uHostPort (
    .busIf      (busIf),
    .arstN      (arstN),
    .csN        (csN),
    .iorN       (iorN),
    .iowN       (iowN),
    .regAddress (regAddress),
    .writeData  (writeData),
    .regOp      (regOp),
    .regChannel (regChannel),
    .regData    (regData),
    .highByte   (highByte)
  );

  channelRegisters uChannelRegisters (
    .busIf           (busIf),
    .arstN           (arstN),
    .regOp           (regOp),
    .regChannel      (regChannel),
    .regData         (regData),
    .highByte        (highByte),
    .dack            (dack),
    .writeBack       (writeBack),
    .tempAddress     (tempAddress),
    .tempCount       (tempCount),
    .curAddress      (curAddress),
    .curCount        (curCount),
    .channelReadByte (channelReadByte)
  );

  controlRegisters uControlRegisters (
    .busIf       (busIf),
    .arstN       (arstN),
    .regOp       (regOp),
    .regData     (regData),
    .dreq        (dreq),
    .dack        (dack),
    .writeBack   (writeBack),
    .tempCount   (tempCount),
    .command     (command),
    .channelMode (channelMode),
    .statusByte  (statusByte)
  );

  transferCounter uTransferCounter (
    .busIf        (busIf),
    .arstN        (arstN),
    .dack         (dack),
    .loadTransfer (loadTransfer),
    .stepTransfer (stepTransfer),
    .curAddress   (curAddress),
    .curCount     (curCount),
    .tempAddress  (tempAddress),
    .tempCount    (tempCount)
  );

  assign memAddress = tempAddress;

  // read data holds until the next read
  always_ff @(posedge busIf or negedge arstN)
  begin
    if (!arstN)
      readData <= '0;
    else if (regOp == opRdStatus)
      readData <= statusByte;
    else if (regOp inside {opRdCurAddress, opRdCurCount})
      readData <= channelReadByte;
  end

endmodule

//--- rtl/transferCounter.sv
`timescale 1ns/1ps

module transferCounter
  import dmaPkg::*;
(
  input  logic                                  busIf,
  input  logic                                  arstN,
  input  logic [channels-1:0]                   dack,
  input  logic                                  loadTransfer,
  input  logic                                  stepTransfer,
  input  logic [channels-1:0][addressWidth-1:0] curAddress,
  input  logic [channels-1:0][addressWidth-1:0] curCount,
  output logic [addressWidth-1:0]               tempAddress,
  output logic [addressWidth-1:0]               tempCount
);

  logic [addressWidth-1:0] selAddress;
  logic [addressWidth-1:0] selCount;
  logic                    anyAck;

  assign anyAck = |dack;

  // dack is one-hot, so an or of the masked words picks the channel
  always_comb
  begin
    selAddress = '0;
    selCount   = '0;
    for (int i = 0; i < channels; i++)
    begin
      if (dack[i])
      begin
        selAddress = selAddress | curAddress[i];
        selCount   = selCount | curCount[i];
      end
    end
  end

  always_ff @(posedge busIf or negedge arstN)
  begin
    if (!arstN)
    begin
      tempAddress <= '0;
      tempCount   <= '0;
    end
    else if (anyAck)
    begin
      if (loadTransfer)
      begin
        tempAddress <= selAddress;
        tempCount   <= selCount;
      end
      else if (stepTransfer)
      begin
        // count wraps past zero
        tempAddress <= tempAddress + addressWidth'(1);
        tempCount   <= tempCount - addressWidth'(1);
      end
    end
  end

endmodule

//--- rtl/controlRegisters.sv
`timescale 1ns/1ps

module controlRegisters
  import dmaPkg::*;
(
  input  logic                               busIf,
  input  logic                               arstN,
  input  regOpT                              regOp,
  input  logic [dataWidth-1:0]               regData,
  input  logic [channels-1:0]                dreq,
  input  logic [channels-1:0]                dack,
  input  logic                               writeBack,
  input  logic [addressWidth-1:0]            tempCount,
  output logic [dataWidth-1:0]               command,
  output logic [channels-1:0][modeWidth-1:0] channelMode,
  output logic [dataWidth-1:0]               statusByte
);

  logic [channels-1:0] tcHit;

  // terminal count only for the acknowledged channel
  assign tcHit = dack & {channels{tempCount == '0}};

  always_ff @(posedge busIf or negedge arstN)
  begin
    if (!arstN)
      command <= '0;
    else if (regOp == opWrCommand)
      command <= regData;
  end

  // low two data bits pick the channel
  always_ff @(posedge busIf or negedge arstN)
  begin
    if (!arstN)
      channelMode <= '0;
    else if (regOp == opWrMode)
      channelMode[regData[1:0]] <= regData[dataWidth-1:dataWidth-modeWidth];
  end

  // requests in the upper nibble, terminal counts in the lower
  always_ff @(posedge busIf or negedge arstN)
  begin
    if (!arstN)
      statusByte <= '0;
    else if (regOp == opRdStatus)
      statusByte <= '0;
    else if (writeBack && (|dack))
      statusByte <= {dreq, statusByte[channels-1:0] | tcHit};
  end

endmodule

//--- rtl/channelRegisters.sv
`timescale 1ns/1ps

module channelRegisters
  import dmaPkg::*;
(
  input  logic                                  busIf,
  input  logic                                  arstN,
  input  regOpT                                 regOp,
  input  logic [1:0]                            regChannel,
  input  logic [dataWidth-1:0]                  regData,
  input  logic                                  highByte,
  input  logic [channels-1:0]                   dack,
  input  logic                                  writeBack,
  input  logic [addressWidth-1:0]               tempAddress,
  input  logic [addressWidth-1:0]               tempCount,
  output logic [channels-1:0][addressWidth-1:0] curAddress,
  output logic [channels-1:0][addressWidth-1:0] curCount,
  output logic [dataWidth-1:0]                  channelReadByte
);

  logic [channels-1:0][addressWidth-1:0] baseAddress;
  logic [channels-1:0][addressWidth-1:0] baseCount;
  logic                                  wrAddress;
  logic                                  wrCount;
  logic [channels-1:0]                   hostHit;
  logic [addressWidth-1:0]               readWord;

  // replace one byte of a 16-bit word
  function automatic logic [addressWidth-1:0] mergeByte(
    input logic [addressWidth-1:0] word,
    input logic [dataWidth-1:0]    data,
    input logic                    high
  );
    logic [addressWidth-1:0] merged;
    merged = word;
    if (high)
      merged[addressWidth-1:dataWidth] = data;
    else
      merged[dataWidth-1:0] = data;
    return merged;
  endfunction

  assign wrAddress = regOp == opWrBaseAddress;
  assign wrCount   = regOp == opWrBaseCount;

  always_comb
  begin
    for (int i = 0; i < channels; i++)
      hostHit[i] = (wrAddress || wrCount) && (regChannel == 2'(i));
  end

  // base values, written by the host only
  always_ff @(posedge busIf)
  begin
    if (wrAddress)
      baseAddress[regChannel] <= mergeByte(baseAddress[regChannel], regData, highByte);
    if (wrCount)
      baseCount[regChannel] <= mergeByte(baseCount[regChannel], regData, highByte);
  end

  // current values, host write beats writeback on the same channel
  always_ff @(posedge busIf or negedge arstN)
  begin
    if (!arstN)
    begin
      curAddress <= '0;
      curCount   <= '0;
    end
    else
    begin
      for (int i = 0; i < channels; i++)
      begin
        if (hostHit[i])
        begin
          if (wrAddress)
            curAddress[i] <= mergeByte(curAddress[i], regData, highByte);
          if (wrCount)
            curCount[i] <= mergeByte(curCount[i], regData, highByte);
        end
        else if (writeBack && dack[i])
        begin
          curAddress[i] <= tempAddress;
          curCount[i]   <= tempCount;
        end
      end
    end
  end

  // readback byte for the registered read op
  always_comb
  begin
    readWord = (regOp == opRdCurCount) ? curCount[regChannel] : curAddress[regChannel];
    if (regOp inside {opRdCurAddress, opRdCurCount})
      channelReadByte = highByte ? readWord[addressWidth-1:dataWidth] : readWord[dataWidth-1:0];
    else
      channelReadByte = '0;
  end

endmodule

//--- rtl/hostPort.sv
`timescale 1ns/1ps

module hostPort
  import dmaPkg::*;
(
  input  logic                 busIf,
  input  logic                 arstN,
  input  logic                 csN,
  input  logic                 iorN,
  input  logic                 iowN,
  input  logic [3:0]           regAddress,
  input  logic [dataWidth-1:0] writeData,
  output regOpT                regOp,
  output logic [1:0]           regChannel,
  output logic [dataWidth-1:0] regData,
  output logic                 highByte
);

  logic       hostWrite;
  logic       hostRead;
  regOpT      decodedOp;
  logic [1:0] decodedChannel;
  logic       pointerAccess;
  logic       bytePointer;

  assign hostWrite = !csN && !iowN && iorN;
  assign hostRead  = !csN && !iorN && iowN;

  always_comb
  begin
    decodedOp      = opNone;
    decodedChannel = regAddress[2:1];
    if (!regAddress[3])
    begin
      // channel registers, bit 0 picks count over address
      if (hostWrite)
        decodedOp = regAddress[0] ? opWrBaseCount : opWrBaseAddress;
      else if (hostRead)
        decodedOp = regAddress[0] ? opRdCurCount : opRdCurAddress;
    end
    else
    begin
      case (regAddress)
        4'd8:
        begin
          if (hostWrite)
            decodedOp = opWrCommand;
          else if (hostRead)
            decodedOp = opRdStatus;
        end
        4'd11:
        begin
          // mode channel comes with the data
          decodedChannel = writeData[1:0];
          if (hostWrite)
            decodedOp = opWrMode;
        end
        4'd12:
        begin
          if (hostWrite)
            decodedOp = opClearPointer;
        end
        default:
          decodedOp = opNone;
      endcase
    end
  end

  assign pointerAccess = decodedOp inside {opWrBaseAddress, opRdCurAddress,
                                           opWrBaseCount, opRdCurCount};

  always_ff @(posedge busIf or negedge arstN)
  begin
    if (!arstN)
    begin
      regOp       <= opNone;
      regChannel  <= '0;
      highByte    <= 1'b0;
      bytePointer <= 1'b0;
    end
    else
    begin
      regOp      <= decodedOp;
      regChannel <= decodedChannel;
      // byte used by this access, pointer moves on for the next one
      highByte   <= bytePointer;
      if (decodedOp == opClearPointer)
        bytePointer <= 1'b0;
      else if (pointerAccess)
        bytePointer <= ~bytePointer;
    end
  end

  always_ff @(posedge busIf)
  begin
    if (hostWrite)
      regData <= writeData;
  end

endmodule

//--- rtl/dmaPkg.sv
package dmaPkg;

  // address and word count registers
  localparam int addressWidth = 16;

  // host data bus
  localparam int dataWidth = 8;

  localparam int channels = 4;

  // mode bits kept per channel, taken from the top of the data byte
  localparam int modeWidth = 6;

  // decoded host access
  typedef enum logic [3:0] {
    opNone,
    opWrBaseAddress,
    opRdCurAddress,
    opWrBaseCount,
    opRdCurCount,
    opWrCommand,
    opWrMode,
    opRdStatus,
    opClearPointer
  } regOpT;

endpackage
